// File: list.f
+incdir+common
+incdir+test
common/miniAluPkg.sv
common/lcdStreamIf.sv
logic/instructionMemory.sv
core/registerFile.sv
core/miniAluCore.sv
lcd/commandQueue.sv
lcd/lcdWriter.sv
logic/miniAluTop.sv
test/tbMiniAlu.sv

// File: Bender.yml
package:
  name: mini_alu

sources:
  - include_dirs:
      - common
    files:
      - common/miniAluPkg.sv
      - common/lcdStreamIf.sv
      - logic/instructionMemory.sv
      - core/registerFile.sv
      - core/miniAluCore.sv
      - lcd/commandQueue.sv
      - lcd/lcdWriter.sv
      - logic/miniAluTop.sv

  - target: test
    include_dirs:
      - common
      - test
    files:
      - test/tbMiniAlu.sv

// File: test/tbTasks.svh
// ----------------------------------------
// compare tasks
// ----------------------------------------
task automatic compareLeds(input string name, input logic [7:0] actual,
	input logic [7:0] expected);
	checkCount++;
	if (actual !== expected)
	begin
		errorCount++;
		$display("[ERROR] %0t %s: got %h, expected %h", $time, name, actual, expected);
	end
endtask

task automatic compareLcdCommand(input string name, input lcdCommand_t actual,
	input lcdCommand_t expected);
	checkCount++;
	if (actual !== expected)
	begin
		errorCount++;
		$display("[ERROR] %0t %s: got rs=%0b data=%h, expected rs=%0b data=%h", $time, name,
			actual.registerSelect, actual.data, expected.registerSelect, expected.data);
	end
endtask

task automatic compareCount(input string name, input int actual, input int expected);
	checkCount++;
	if (actual != expected)
	begin
		errorCount++;
		$display("[ERROR] %0t %s: got %0d, expected %0d", $time, name, actual, expected);
	end
endtask

// ----------------------------------------
// program building and expected results
// ----------------------------------------
function automatic void emit(input opcode_t op, input logic [7:0] dest,
	input logic [7:0] src1, input logic [7:0] src0);
	instruction_t word;
	word.operation   = op;
	word.destination = dest;
	word.sourceAddr1 = src1;
	word.sourceAddr0 = src0;
	programImage.push_back(word);
endfunction

// immediate split over the two source fields
function automatic void emitStore(input logic [7:0] dest, input logic [15:0] value);
	emit(STO, dest, value[15:8], value[7:0]);
endfunction

// jump to itself so the core idles
function automatic void emitHalt();
	emit(JMP, 8'(programImage.size()), 8'd0, 8'd0);
endfunction

function automatic void expectByte(input logic select, input logic [7:0] data);
	lcdCommand_t command;
	command.registerSelect = select;
	command.data           = data;
	expectedBytes.push_back(command);
endfunction

function automatic void emitMarker();
	emit(LCDC, 8'd0, MarkerReg, 8'd0);
	expectByte(1'b0, MarkerByte);
endfunction

// leds only shows a change when the value differs
function automatic void expectLed(input logic [7:0] value);
	if (value !== ledModel)
	begin
		expectedLeds.push_back(value);
	end
	ledModel = value;
endfunction

// ----------------------------------------
// DUT control
// ----------------------------------------
task automatic restartDut();
	@(posedge Clock);
	#1;
	run = 1'b0;
	rst = 1'b1;
	repeat (2) @(posedge Clock);
	#1;
	rst = 1'b0;
	programImage.delete();
	expectedBytes.delete();
	receivedBytes.delete();
	expectedLeds.delete();
	ledHistory.delete();
	ledModel   = 8'h00;
	pulseTotal = 0;
	emitStore(MarkerReg, {8'h00, MarkerByte});
endtask

task automatic loadAndRun();
	for (int i = 0; i < programImage.size(); i++)
	begin
		@(posedge Clock);
		#1;
		loadEnable      = 1'b1;
		loadAddress     = 8'(i);
		loadInstruction = programImage[i];
	end
	@(posedge Clock);
	#1;
	loadEnable = 1'b0;
	run        = 1'b1;
endtask

task automatic waitForBytes(input int count);
	while (receivedBytes.size() < count)
	begin
		@(posedge Clock);
	end
endtask

// one more byte time so a stray extra byte would show up
task automatic checkResults(input string label);
	waitForBytes(expectedBytes.size());
	repeat (ByteCycles) @(posedge Clock);
	compareCount({label, " byte count"}, receivedBytes.size(), expectedBytes.size());
	for (int i = 0; i < expectedBytes.size() && i < receivedBytes.size(); i++)
	begin
		compareLcdCommand({label, " display byte"}, receivedBytes[i], expectedBytes[i]);
	end
	compareCount({label, " leds changes"}, ledHistory.size(), expectedLeds.size());
	for (int i = 0; i < expectedLeds.size() && i < ledHistory.size(); i++)
	begin
		compareLeds({label, " leds"}, ledHistory[i], expectedLeds[i]);
	end
endtask

// ----------------------------------------
// directed tests
// ----------------------------------------
task automatic storeThenShow();
	logic [15:0] immediate;
	restartDut();
	immediate = 16'($urandom);
	emitStore(8'd1, immediate);
	emit(LED, 8'd0, 8'd1, 8'd0);
	expectLed(immediate[7:0]);
	emitMarker();
	emitHalt();
	loadAndRun();
	checkResults("store and show");
endtask

task automatic randomAddSub();
	logic [15:0] a;
	logic [15:0] b;
	logic [15:0] sum;
	logic [15:0] difference;
	for (int pair = 0; pair < 8; pair++)
	begin
		restartDut();
		a          = 16'($urandom);
		b          = 16'($urandom);
		sum        = a + b;
		difference = a - b;
		emitStore(8'd1, a);
		emitStore(8'd2, b);
		// LED right behind the ADD reads the fresh result
		emit(ADD, 8'd3, 8'd1, 8'd2);
		emit(LED, 8'd0, 8'd3, 8'd0);
		expectLed(sum[7:0]);
		emit(SUB, 8'd4, 8'd1, 8'd2);
		emit(LED, 8'd0, 8'd4, 8'd0);
		expectLed(difference[7:0]);
		emitMarker();
		emitHalt();
		loadAndRun();
		checkResults("add and subtract");
	end
endtask

// bound lies above 0x8000, a signed compare would leave the loop early
task automatic countingLoop();
	logic [15:0] value;
	logic [7:0]  loopTop;
	restartDut();
	emitStore(8'd1, LoopStart);
	emitStore(8'd2, 16'd1);
	emitStore(8'd4, LoopStart + 16'(LoopSteps - 1));
	loopTop = 8'(programImage.size());
	emit(ADD, 8'd1, 8'd1, 8'd2);
	emit(LED, 8'd0, 8'd1, 8'd0);
	emit(BLE, loopTop, 8'd1, 8'd4);
	// squashed on every taken branch, runs once on exit
	emitMarker();
	emitHalt();
	for (int step = 1; step <= LoopSteps; step++)
	begin
		value = LoopStart + 16'(step);
		expectLed(value[7:0]);
	end
	loadAndRun();
	checkResults("counting loop");
endtask

// ten back to back pushes into a four deep queue
task automatic displayBurst();
	logic [7:0] data [10];
	logic       select;
	restartDut();
	for (int i = 0; i < 10; i++)
	begin
		data[i] = 8'($urandom);
		emitStore(8'(10 + i), {8'h00, data[i]});
	end
	for (int i = 0; i < 10; i++)
	begin
		select = ((i % 3) != 1);
		if (select)
		begin
			emit(LCD, 8'd0, 8'(10 + i), 8'd0);
		end
		else
		begin
			emit(LCDC, 8'd0, 8'(10 + i), 8'd0);
		end
		expectByte(select, data[i]);
	end
	emitHalt();
	loadAndRun();
	checkResults("display burst");
	compareCount("enable pulses", pulseTotal, 2 * expectedBytes.size());
endtask

task automatic resetWithPending();
	int bytesBefore;
	restartDut();
	emitStore(8'd1, 16'h005a);
	emit(LED, 8'd0, 8'd1, 8'd0);
	for (int i = 0; i < 6; i++)
	begin
		emitStore(8'(10 + i), 16'($urandom));
		emit(LCD, 8'd0, 8'(10 + i), 8'd0);
	end
	emitHalt();
	loadAndRun();
	waitForBytes(1);
	@(posedge Clock);
	#1;
	compareLeds("leds before reset", leds, 8'h5a);
	run = 1'b0;
	rst = 1'b1;
	repeat (2) @(posedge Clock);
	#1;
	rst              = 1'b0;
	bytesBefore      = receivedBytes.size();
	enableHighCycles = 0;
	compareLeds("leds after reset", leds, 8'h00);
	repeat (2 * ByteCycles) @(posedge Clock);
	compareCount("lcdEnable high cycles after reset", enableHighCycles, 0);
	compareCount("bytes after reset", receivedBytes.size(), bytesBefore);
endtask

// File: test/tbMiniAlu.sv
`timescale 1ns/10ps
`include "miniAlu_macros.svh"

module tbMiniAlu;
	import miniAluPkg::*;

	// one display byte is two nibbles, each a pulse plus a gap
	localparam int ByteCycles         = 2 * (`LCD_PULSE_CYCLES + `LCD_GAP_CYCLES);
	localparam int ResetCycles        = 10;
	localparam int StoreLedCycles     = 30 + 2 * ByteCycles;
	localparam int AddSubCycles       = 8 * (30 + 2 * ByteCycles);
	localparam int LoopCycles         = 60 + 2 * ByteCycles;
	localparam int BurstCycles        = 60 + 11 * ByteCycles;
	localparam int ResetPendingCycles = 40 + 3 * ByteCycles;
	localparam int TimeoutCycles      = 2 * (ResetCycles + StoreLedCycles + AddSubCycles +
		LoopCycles + BurstCycles + ResetPendingCycles);

	// register holding the end-of-program display byte
	localparam logic [7:0]  MarkerReg  = 8'd200;
	localparam logic [7:0]  MarkerByte = 8'h0c;
	// counting loop crosses 0x8000
	localparam logic [15:0] LoopStart  = 16'h7ffc;
	localparam int          LoopSteps  = 6;

	logic                   Clock;
	logic                   rst;
	logic                   run;
	logic                   loadEnable;
	logic [`ADDR_WIDTH-1:0] loadAddress;
	instruction_t           loadInstruction;
	logic [7:0]             leds;
	logic                   lcdEnable;
	logic                   lcdRegisterSelect;
	logic [3:0]             lcdData;

	int           errorCount;
	int           checkCount;
	int           cycleCount;
	instruction_t programImage [$];
	lcdCommand_t  expectedBytes [$];
	lcdCommand_t  receivedBytes [$];
	logic [7:0]   expectedLeds [$];
	logic [7:0]   ledHistory [$];
	logic [7:0]   ledModel;

	// display monitor state
	int          pulseLength;
	int          pulseTotal;
	int          enableHighCycles;
	logic [3:0]  pulseNibble;
	logic        pulseSelect;
	logic [3:0]  upperNibble;
	logic        upperSelect;
	logic        haveUpper;
	lcdCommand_t assembled;

	miniAluTop u_dut
	(
		.Clock             (Clock),
		.rst               (rst),
		.run               (run),
		.loadEnable        (loadEnable),
		.loadAddress       (loadAddress),
		.loadInstruction   (loadInstruction),
		.leds              (leds),
		.lcdEnable         (lcdEnable),
		.lcdRegisterSelect (lcdRegisterSelect),
		.lcdData           (lcdData)
	);

	`include "tbTasks.svh"

	always #2 Clock = ~Clock;

	// ----------------------------------------
	// cycle budget
	// ----------------------------------------
	always @(posedge Clock)
	begin
		cycleCount++;
		if (cycleCount > TimeoutCycles)
		begin
			$display("timeout: tests did not finish within %0d cycles", TimeoutCycles);
			$display("checks run: %0d, errors: %0d", checkCount, errorCount);
			$display("=== FAIL ===");
			$finish;
		end
	end

	// every change of leds outside reset
	always @(leds)
	begin
		if (rst === 1'b0)
		begin
			ledHistory.push_back(leds);
		end
	end

	// ----------------------------------------
	// display monitor, sampled mid-cycle
	// ----------------------------------------
	always @(negedge Clock)
	begin
		if (rst !== 1'b0)
		begin
			pulseLength = 0;
			haveUpper   = 1'b0;
		end
		else if (lcdEnable)
		begin
			if (pulseLength == 0)
			begin
				pulseNibble = lcdData;
				pulseSelect = lcdRegisterSelect;
			end
			else if (lcdData !== pulseNibble || lcdRegisterSelect !== pulseSelect)
			begin
				errorCount++;
				$display("display pins changed during an enable pulse at %0t", $time);
			end
			pulseLength++;
			enableHighCycles++;
		end
		else if (pulseLength != 0)
		begin
			compareCount("lcdEnable pulse cycles", pulseLength, `LCD_PULSE_CYCLES);
			pulseLength = 0;
			pulseTotal++;
			if (!haveUpper)
			begin
				upperNibble = pulseNibble;
				upperSelect = pulseSelect;
				haveUpper   = 1'b1;
			end
			else
			begin
				if (upperSelect !== pulseSelect)
				begin
					errorCount++;
					$display("register select differs between the two nibbles at %0t", $time);
				end
				// upper nibble came first
				assembled.registerSelect = pulseSelect;
				assembled.data           = {upperNibble, pulseNibble};
				receivedBytes.push_back(assembled);
				haveUpper = 1'b0;
			end
		end
	end

	initial
	begin
		void'($urandom(32'hd3b0));
		Clock            = 1'b0;
		rst              = 1'b1;
		run              = 1'b0;
		loadEnable       = 1'b0;
		loadAddress      = '0;
		loadInstruction  = '0;
		errorCount       = 0;
		checkCount       = 0;
		cycleCount       = 0;
		pulseLength      = 0;
		pulseTotal       = 0;
		enableHighCycles = 0;
		haveUpper        = 1'b0;
		ledModel         = 8'h00;
		repeat (ResetCycles) @(posedge Clock);
		#1;
		rst = 1'b0;

		storeThenShow();
		randomAddSub();
		countingLoop();
		displayBurst();
		resetWithPending();

		$display("checks run: %0d, errors: %0d", checkCount, errorCount);
		if (errorCount == 0)
		begin
			$display("=== PASS ===");
		end
		else
		begin
			$display("=== FAIL ===");
		end
		$finish;
	end

endmodule

// File: logic/miniAluTop.sv
`timescale 1ns/10ps
`include "miniAlu_macros.svh"

module miniAluTop
(
	input  logic                     Clock,
	input  logic                     rst,
	input  logic                     run,
	input  logic                     loadEnable,
	input  logic [`ADDR_WIDTH-1:0]   loadAddress,
	input  miniAluPkg::instruction_t loadInstruction,
	output logic [7:0]               leds,
	output logic                     lcdEnable,
	output logic                     lcdRegisterSelect,
	output logic [3:0]               lcdData
);
	import miniAluPkg::*;

	logic [`ADDR_WIDTH-1:0] fetchAddress;
	instruction_t           fetchInstruction;

	// core to queue, queue to writer
	lcdStreamIf coreToQueue ();
	lcdStreamIf queueToWriter ();

	instructionMemory u_instructionMemory
	(
		.Clock            (Clock),
		.loadEnable       (loadEnable),
		.loadAddress      (loadAddress),
		.loadInstruction  (loadInstruction),
		.fetchAddress     (fetchAddress),
		.fetchInstruction (fetchInstruction)
	);

	miniAluCore u_miniAluCore
	(
		.Clock            (Clock),
		.rst              (rst),
		.run              (run),
		.fetchAddress     (fetchAddress),
		.fetchInstruction (fetchInstruction),
		.lcdOut           (coreToQueue.producer),
		.leds             (leds)
	);

	commandQueue #(.Depth(`QUEUE_DEPTH)) u_commandQueue
	(
		.Clock    (Clock),
		.rst      (rst),
		.pushSide (coreToQueue.consumer),
		.popSide  (queueToWriter.producer)
	);

	lcdWriter u_lcdWriter
	(
		.Clock             (Clock),
		.rst               (rst),
		.commandIn         (queueToWriter.consumer),
		.lcdEnable         (lcdEnable),
		.lcdRegisterSelect (lcdRegisterSelect),
		.lcdData           (lcdData)
	);

endmodule

// File: lcd/lcdWriter.sv
`timescale 1ns/10ps
`include "miniAlu_macros.svh"

module lcdWriter
(
	input  logic         Clock,
	input  logic         rst,
	lcdStreamIf.consumer commandIn,
	output logic         lcdEnable,
	output logic         lcdRegisterSelect,
	output logic [3:0]   lcdData
);
	import miniAluPkg::*;

	localparam int LongestPhase = (`LCD_GAP_CYCLES > `LCD_PULSE_CYCLES) ?
		`LCD_GAP_CYCLES : `LCD_PULSE_CYCLES;
	localparam int CountWidth = (LongestPhase > 1) ? $clog2(LongestPhase) : 1;
	localparam logic [CountWidth-1:0] PulseLast = CountWidth'(`LCD_PULSE_CYCLES - 1);
	localparam logic [CountWidth-1:0] GapLast   = CountWidth'(`LCD_GAP_CYCLES - 1);

	typedef enum logic [2:0]
	{
		IDLE,
		HIGH_PULSE,
		HIGH_GAP,
		LOW_PULSE,
		LOW_GAP
	} writerState_t;

	writerState_t          state;
	logic [CountWidth-1:0] cycleCount;
	lcdCommand_t           current;

	// only take a new byte once both nibbles are out
	assign commandIn.ready = (state == IDLE);

	// ----------------------------------------
	// nibble sequencing
	// ----------------------------------------
	always_ff @(posedge Clock)
	begin
		if (rst)
		begin
			state      <= IDLE;
			cycleCount <= '0;
			current    <= '0;
		end
		else
		begin
			cycleCount <= cycleCount + 1'b1;
			case (state)
				IDLE:
				begin
					cycleCount <= '0;
					if (commandIn.valid)
					begin
						current <= commandIn.command;
						state   <= HIGH_PULSE;
					end
				end
				HIGH_PULSE:
				begin
					if (cycleCount == PulseLast)
					begin
						cycleCount <= '0;
						state      <= HIGH_GAP;
					end
				end
				HIGH_GAP:
				begin
					if (cycleCount == GapLast)
					begin
						cycleCount <= '0;
						state      <= LOW_PULSE;
					end
				end
				LOW_PULSE:
				begin
					if (cycleCount == PulseLast)
					begin
						cycleCount <= '0;
						state      <= LOW_GAP;
					end
				end
				default:
				begin
					if (cycleCount == GapLast)
					begin
						cycleCount <= '0;
						state      <= IDLE;
					end
				end
			endcase
		end
	end

	// pins follow the state, stable across each pulse
	assign lcdEnable         = (state == HIGH_PULSE) || (state == LOW_PULSE);
	assign lcdRegisterSelect = current.registerSelect;
	assign lcdData           = ((state == HIGH_PULSE) || (state == HIGH_GAP)) ?
		current.data[7:4] : current.data[3:0];

endmodule

// File: lcd/commandQueue.sv
`timescale 1ns/10ps
`include "miniAlu_macros.svh"

module commandQueue
#(
	parameter int Depth = `QUEUE_DEPTH
)
(
	input  logic         Clock,
	input  logic         rst,
	lcdStreamIf.consumer pushSide,
	lcdStreamIf.producer popSide
);
	import miniAluPkg::*;

	localparam int PointerWidth = (Depth > 1) ? $clog2(Depth) : 1;
	localparam int CountWidth   = $clog2(Depth + 1);

	lcdCommand_t             storage [Depth];
	logic [PointerWidth-1:0] writePointer;
	logic [PointerWidth-1:0] readPointer;
	logic [CountWidth-1:0]   count;
	logic                    push;
	logic                    pop;

	assign pushSide.ready  = (count < CountWidth'(Depth));
	assign popSide.valid   = (count != '0);
	assign popSide.command = storage[readPointer];

	assign push = pushSide.valid & pushSide.ready;
	assign pop  = popSide.valid & popSide.ready;

	// payload storage
	always_ff @(posedge Clock)
	begin
		if (push)
		begin
			storage[writePointer] <= pushSide.command;
		end
	end

	// ----------------------------------------
	// pointers and occupancy
	// ----------------------------------------
	always_ff @(posedge Clock)
	begin
		if (rst)
		begin
			writePointer <= '0;
			readPointer  <= '0;
			count        <= '0;
		end
		else
		begin
			if (push)
			begin
				writePointer <= writePointer + 1'b1;
			end
			if (pop)
			begin
				readPointer <= readPointer + 1'b1;
			end
			// simultaneous push and pop leaves count alone
			if (push && !pop)
			begin
				count <= count + 1'b1;
			end
			else if (pop && !push)
			begin
				count <= count - 1'b1;
			end
		end
	end

endmodule

// File: core/miniAluCore.sv
`timescale 1ns/10ps
`include "miniAlu_macros.svh"

module miniAluCore
(
	input  logic                     Clock,
	input  logic                     rst,
	input  logic                     run,
	output logic [`ADDR_WIDTH-1:0]   fetchAddress,
	input  miniAluPkg::instruction_t fetchInstruction,
	lcdStreamIf.producer             lcdOut,
	output logic [7:0]               leds
);
	import miniAluPkg::*;

	localparam instruction_t NopInstruction = '{NOP, 8'd0, 8'd0, 8'd0};

	logic [`ADDR_WIDTH-1:0] programCounter;
	instruction_t           decoded;
	logic [`DATA_WIDTH-1:0] sourceData0;
	logic [`DATA_WIDTH-1:0] sourceData1;
	logic [`DATA_WIDTH-1:0] immediateValue;
	logic [`DATA_WIDTH-1:0] result;
	logic                   writeEnable;
	logic                   branchTaken;
	logic                   ledEnable;
	logic                   lcdPush;
	logic                   lcdRegisterSelect;
	logic                   stall;

	registerFile u_registerFile
	(
		.Clock        (Clock),
		.writeEnable  (writeEnable),
		.writeAddress (decoded.destination),
		.writeData    (result),
		.readAddress0 (decoded.sourceAddr0),
		.readAddress1 (decoded.sourceAddr1),
		.readData0    (sourceData0),
		.readData1    (sourceData1)
	);

	assign immediateValue = {decoded.sourceAddr1, decoded.sourceAddr0};
	assign fetchAddress   = programCounter;

	// ----------------------------------------
	// execute
	// ----------------------------------------
	always_comb
	begin
		writeEnable       = 1'b0;
		branchTaken       = 1'b0;
		ledEnable         = 1'b0;
		lcdPush           = 1'b0;
		lcdRegisterSelect = 1'b0;
		result            = '0;
		case (decoded.operation)
			ADD:
			begin
				writeEnable = 1'b1;
				result      = sourceData1 + sourceData0;
			end
			SUB:
			begin
				writeEnable = 1'b1;
				result      = sourceData1 - sourceData0;
			end
			STO:
			begin
				writeEnable = 1'b1;
				result      = immediateValue;
			end
			// unsigned compare
			BLE:
			begin
				branchTaken = (sourceData1 <= sourceData0);
			end
			JMP:
			begin
				branchTaken = 1'b1;
			end
			LED:
			begin
				ledEnable = 1'b1;
			end
			LCD:
			begin
				lcdPush           = 1'b1;
				lcdRegisterSelect = 1'b1;
			end
			LCDC:
			begin
				lcdPush = 1'b1;
			end
			// NOP and unused codes do nothing
			default:
			begin
			end
		endcase
	end

	// display push, held until the queue takes it
	assign lcdOut.valid          = lcdPush;
	assign lcdOut.command.registerSelect = lcdRegisterSelect;
	assign lcdOut.command.data   = sourceData1[7:0];
	assign stall                 = lcdPush & ~lcdOut.ready;

	// ----------------------------------------
	// fetch and decode register
	// ----------------------------------------
	always_ff @(posedge Clock)
	begin
		if (rst || !run)
		begin
			programCounter <= '0;
			decoded        <= NopInstruction;
		end
		else if (!stall)
		begin
			if (branchTaken)
			begin
				// squash the instruction fetched behind the branch
				programCounter <= decoded.destination;
				decoded        <= NopInstruction;
			end
			else
			begin
				programCounter <= programCounter + 1'b1;
				decoded        <= fetchInstruction;
			end
		end
	end

	// led register
	always_ff @(posedge Clock)
	begin
		if (rst)
		begin
			leds <= '0;
		end
		else if (ledEnable)
		begin
			leds <= sourceData1[7:0];
		end
	end

endmodule

// File: core/registerFile.sv
`timescale 1ns/10ps
`include "miniAlu_macros.svh"

module registerFile
(
	input  logic                   Clock,
	input  logic                   writeEnable,
	input  logic [`ADDR_WIDTH-1:0] writeAddress,
	input  logic [`DATA_WIDTH-1:0] writeData,
	input  logic [`ADDR_WIDTH-1:0] readAddress0,
	input  logic [`ADDR_WIDTH-1:0] readAddress1,
	output logic [`DATA_WIDTH-1:0] readData0,
	output logic [`DATA_WIDTH-1:0] readData1
);

	localparam int Words = 1 << `ADDR_WIDTH;

	logic [`DATA_WIDTH-1:0] registers [Words];

	// single write port, lands at end of execute cycle
	always_ff @(posedge Clock)
	begin
		if (writeEnable)
		begin
			registers[writeAddress] <= writeData;
		end
	end

	// two independent read ports
	assign readData0 = registers[readAddress0];
	assign readData1 = registers[readAddress1];

endmodule

// File: logic/instructionMemory.sv
`timescale 1ns/10ps
`include "miniAlu_macros.svh"

module instructionMemory
(
	input  logic                     Clock,
	input  logic                     loadEnable,
	input  logic [`ADDR_WIDTH-1:0]   loadAddress,
	input  miniAluPkg::instruction_t loadInstruction,
	input  logic [`ADDR_WIDTH-1:0]   fetchAddress,
	output miniAluPkg::instruction_t fetchInstruction
);
	import miniAluPkg::*;

	localparam int Entries = 1 << `ADDR_WIDTH;

	instruction_t contents [Entries];

	// program load only happens while the core is idle
	always_ff @(posedge Clock)
	begin
		if (loadEnable)
		begin
			contents[loadAddress] <= loadInstruction;
		end
	end

	// combinational fetch like a ROM
	assign fetchInstruction = contents[fetchAddress];

endmodule

// File: common/lcdStreamIf.sv
`timescale 1ns/10ps

interface lcdStreamIf;
	import miniAluPkg::*;

	logic        valid;
	logic        ready;
	lcdCommand_t command;

	// side that offers commands
	modport producer
	(
		output valid,
		output command,
		input  ready
	);

	// side that takes commands
	modport consumer
	(
		input  valid,
		input  command,
		output ready
	);

endinterface

// File: common/miniAluPkg.sv
`include "miniAlu_macros.svh"

package miniAluPkg;

	// ----------------------------------------
	// instruction set
	// ----------------------------------------
	typedef enum logic [3:0]
	{
		NOP  = 4'd0,
		ADD  = 4'd1,
		SUB  = 4'd2,
		STO  = 4'd3,
		BLE  = 4'd4,
		JMP  = 4'd5,
		LED  = 4'd6,
		LCD  = 4'd7,
		LCDC = 4'd8
	} opcode_t;

	// immediate is {sourceAddr1, sourceAddr0}, branch target is destination
	typedef struct packed
	{
		opcode_t                operation;
		logic [`ADDR_WIDTH-1:0] destination;
		logic [`ADDR_WIDTH-1:0] sourceAddr1;
		logic [`ADDR_WIDTH-1:0] sourceAddr0;
	} instruction_t;

	// ----------------------------------------
	// display command
	// ----------------------------------------
	// registerSelect: 1 data, 0 command
	typedef struct packed
	{
		logic       registerSelect;
		logic [7:0] data;
	} lcdCommand_t;

endpackage

// File: common/miniAlu_macros.svh
`ifndef MINI_ALU_MACROS_SVH
`define MINI_ALU_MACROS_SVH

// datapath widths
`define DATA_WIDTH 16
`define ADDR_WIDTH 8
`define INSTR_WIDTH 28

// display command queue
`define QUEUE_DEPTH 4

// enable pulse shaping per nibble, in clock cycles
`define LCD_PULSE_CYCLES 4
`define LCD_GAP_CYCLES 6

`endif
